// ==== verilog.f ====
rtl/mem_dram_pkg.sv
rtl/sync_fifo.sv
rtl/dram_word_sequencer.sv
rtl/write_data_serializer.sv
rtl/read_reorder_buffer.sv
rtl/read_data_assembler.sv
rtl/mem_to_dram.sv
rtl/dram_channel.sv
rtl/mem_dram_top.sv
verification/tb_clock_gen.sv
verification/tb_mem_dram.sv

// ==== Makefile ====
SRCS := $(shell grep -v '^+' verilog.f)
SIM  := obj_dir/Vtb_mem_dram

.PHONY: all run clean

all: run

$(SIM): verilog.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module tb_mem_dram -f verilog.f

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// ==== verification/tb_mem_dram.sv ====
module tb_mem_dram;

  localparam int num_cmds_lp    = 400;
  localparam int num_blocks_lp  = 8;
  localparam int total_cmds_lp  = num_blocks_lp + num_cmds_lp;
  localparam int cycle_limit_lp = num_cmds_lp * 60;
  localparam int msg_w_lp       = $bits(mem_dram_pkg::mem_msg_s);
  localparam logic [31:0] dram_base_lp = 32'h8000_0000;

  logic clk, reset;
  mem_dram_pkg::mem_msg_s mem_cmd, mem_resp, held_resp;
  logic mem_cmd_v, mem_cmd_ready, mem_resp_v, mem_resp_yumi;

  mem_dram_pkg::mem_msg_s expected_q [$];
  logic [7:0] model_mem [num_blocks_lp * 32];
  integer seed;
  int cycle, sent, received;
  bit held_valid, done;

  tb_clock_gen clock_gen (
    .clk_o  (clk),
    .reset_o(reset)
  );

  mem_dram_top #(
    .word_width_p(64),
    .fifo_els_p  (4),
    .dram_base_p (dram_base_lp),
    .mem_words_p (512)
  ) dut (
    .clk_i          (clk),
    .reset_i        (reset),
    .mem_cmd_i      (mem_cmd),
    .mem_cmd_v_i    (mem_cmd_v),
    .mem_cmd_ready_o(mem_cmd_ready),
    .mem_resp_o     (mem_resp),
    .mem_resp_v_o   (mem_resp_v),
    .mem_resp_yumi_i(mem_resp_yumi)
  );

  task automatic stop_on_error();
    $display("Checks failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input logic [msg_w_lp-1:0] actual,
                             input logic [msg_w_lp-1:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("MISMATCH at time %0t: %s, got %h, expected %h", $time, what, actual, expected);
      stop_on_error();
    end
  endtask

  // the first commands write whole blocks so every later read has known bytes
  task automatic make_command(input int index, output mem_dram_pkg::mem_msg_s cmd);
    int size;
    int nbytes;
    int off;
    logic [7:0] pat [32];
    for (int b = 0; b < 32; b++) begin
      pat[b] = 8'($random(seed));
    end
    if (index < num_blocks_lp) begin
      size = 5;
      off  = index * 32;
      cmd.header.msg_type = mem_dram_pkg::e_mem_wr;
    end else begin
      size = ($random(seed) & 32'h7fff_ffff) % 6;
      off  = ($random(seed) & 32'hff) & ~((1 << size) - 1);
      cmd.header.msg_type = mem_dram_pkg::mem_msg_type_e'(2'($random(seed)));
    end
    nbytes          = 1 << size;
    cmd.header.size = mem_dram_pkg::mem_size_e'(3'(size));
    cmd.header.addr = dram_base_lp + 32'(off);
    // pattern repeats every 2^size bytes
    for (int b = 0; b < 32; b++) begin
      cmd.data[b*8 +: 8] = pat[b % nbytes];
    end
  endtask

  task automatic record_command(input mem_dram_pkg::mem_msg_s cmd);
    mem_dram_pkg::mem_msg_s exp;
    int nbytes;
    int off;
    bit is_write;
    nbytes   = 1 << int'(cmd.header.size);
    off      = int'(cmd.header.addr - dram_base_lp);
    is_write = (cmd.header.msg_type == mem_dram_pkg::e_mem_wr)
            || (cmd.header.msg_type == mem_dram_pkg::e_mem_uc_wr);
    exp.header = cmd.header;
    exp.data   = '0;
    if (is_write) begin
      for (int i = 0; i < nbytes; i++) begin
        model_mem[off + i] = cmd.data[i*8 +: 8];
      end
    end else begin
      // requested bytes replicated over the block
      for (int b = 0; b < 32; b++) begin
        exp.data[b*8 +: 8] = model_mem[off + (b % nbytes)];
      end
    end
    expected_q.push_back(exp);
  endtask

  task automatic check_response(input mem_dram_pkg::mem_msg_s resp);
    mem_dram_pkg::mem_msg_s exp;
    if (expected_q.size() == 0) begin
      $display("a response arrived at time %0t with no command outstanding", $time);
      stop_on_error();
    end
    exp = expected_q.pop_front();
    check_value(msg_w_lp'(resp.header), msg_w_lp'(exp.header), "response header");
    check_value(msg_w_lp'(resp.data), msg_w_lp'(exp.data), "response data");
  endtask

  initial begin
    mem_dram_pkg::mem_msg_s next_cmd;
    seed          = 32'h628c712d;
    mem_cmd       = '0;
    mem_cmd_v     = 1'b0;
    mem_resp_yumi = 1'b0;
    cycle         = 0;
    sent          = 0;
    received      = 0;
    held_valid    = 1'b0;
    done          = 1'b0;
    while (!done) begin
      @(posedge clk);
      cycle++;
      if (reset) begin
        // state is only defined after the first reset edge
        if (cycle > 1) begin
          check_value(msg_w_lp'(mem_cmd_ready), msg_w_lp'(0), "command ready during reset");
          check_value(msg_w_lp'(mem_resp_v), msg_w_lp'(0), "response valid during reset");
        end
      end else begin
        if (cycle > cycle_limit_lp) begin
          $display("timeout after %0d cycles, %0d of %0d responses received",
                   cycle, received, total_cmds_lp);
          stop_on_error();
        end

        if (mem_cmd_v && mem_cmd_ready) begin
          record_command(mem_cmd);
          sent++;
          mem_cmd_v <= 1'b0;
        end
        if ((!mem_cmd_v || mem_cmd_ready) && sent < total_cmds_lp
            && ($random(seed) & 3) != 0) begin
          make_command(sent, next_cmd);
          mem_cmd   <= next_cmd;
          mem_cmd_v <= 1'b1;
        end

        if (held_valid) begin
          check_value(msg_w_lp'(mem_resp_v), msg_w_lp'(1), "response valid dropped before yumi");
          check_value(mem_resp, held_resp, "response changed while yumi low");
        end
        held_valid = 1'b0;
        if (mem_resp_v && mem_resp_yumi) begin
          check_response(mem_resp);
          received++;
        end else if (mem_resp_v) begin
          held_valid = 1'b1;
          held_resp  = mem_resp;
        end
        // valid is sticky until consumed, so yumi follows a held response
        // stall windows let the queues fill up
        mem_resp_yumi <= mem_resp_v && !mem_resp_yumi && (cycle % 400 >= 80)
                         && (($random(seed) & 1) != 0);

        if (sent == total_cmds_lp && received == total_cmds_lp) begin
          done = 1'b1;
        end
      end
    end
    // no response may follow the last one
    repeat (20) begin
      @(posedge clk);
      check_value(msg_w_lp'(mem_resp_v), msg_w_lp'(0), "response valid after the last command");
    end
    $display("All checks passed");
    $finish;
  end

endmodule

// ==== verification/tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int half_period_p  = 5,
  parameter int reset_cycles_p = 4
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(half_period_p) clk_o = ~clk_o;
    end
  end

  initial begin
    reset_o = 1'b1;
    repeat (reset_cycles_p) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// ==== rtl/mem_dram_top.sv ====
module mem_dram_top #(
  parameter int          word_width_p = 64,
  parameter int          fifo_els_p   = 4,
  parameter logic [31:0] dram_base_p  = 32'h8000_0000,
  parameter int          mem_words_p  = 512
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  mem_dram_pkg::mem_msg_s mem_cmd_i,
  input  logic                   mem_cmd_v_i,
  output logic                   mem_cmd_ready_o,
  output mem_dram_pkg::mem_msg_s mem_resp_o,
  output logic                   mem_resp_v_o,
  input  logic                   mem_resp_yumi_i
);

  mem_dram_pkg::dram_cmd_s dram_cmd;
  logic dram_cmd_v, dram_cmd_yumi, dram_wdata_v, dram_wdata_yumi;
  logic dram_rdata_v, dram_rdata_ready;
  logic [word_width_p-1:0]   dram_wdata, dram_rdata;
  logic [word_width_p/8-1:0] dram_wmask;
  logic [mem_dram_pkg::ch_addr_width-1:0] dram_rtag;

  mem_to_dram #(
    .word_width_p(word_width_p),
    .fifo_els_p  (fifo_els_p),
    .dram_base_p (dram_base_p)
  ) bridge (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .mem_cmd_i         (mem_cmd_i),
    .mem_cmd_v_i       (mem_cmd_v_i),
    .mem_cmd_ready_o   (mem_cmd_ready_o),
    .mem_resp_o        (mem_resp_o),
    .mem_resp_v_o      (mem_resp_v_o),
    .mem_resp_yumi_i   (mem_resp_yumi_i),
    .dram_cmd_o        (dram_cmd),
    .dram_cmd_v_o      (dram_cmd_v),
    .dram_cmd_yumi_i   (dram_cmd_yumi),
    .dram_wdata_o      (dram_wdata),
    .dram_wmask_o      (dram_wmask),
    .dram_wdata_v_o    (dram_wdata_v),
    .dram_wdata_yumi_i (dram_wdata_yumi),
    .dram_rdata_i      (dram_rdata),
    .dram_rtag_i       (dram_rtag),
    .dram_rdata_v_i    (dram_rdata_v),
    .dram_rdata_ready_o(dram_rdata_ready)
  );

  dram_channel #(
    .word_width_p(word_width_p),
    .mem_words_p (mem_words_p)
  ) channel (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd_i        (dram_cmd),
    .cmd_v_i      (dram_cmd_v),
    .cmd_yumi_o   (dram_cmd_yumi),
    .wdata_i      (dram_wdata),
    .wmask_i      (dram_wmask),
    .wdata_v_i    (dram_wdata_v),
    .wdata_yumi_o (dram_wdata_yumi),
    .rdata_o      (dram_rdata),
    .rtag_o       (dram_rtag),
    .rdata_v_o    (dram_rdata_v),
    .rdata_ready_i(dram_rdata_ready)
  );

endmodule

// ==== rtl/dram_channel.sv ====
module dram_channel #(
  parameter int word_width_p = 64,
  parameter int mem_words_p  = 512
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  mem_dram_pkg::dram_cmd_s                cmd_i,
  input  logic                                   cmd_v_i,
  output logic                                   cmd_yumi_o,
  input  logic [word_width_p-1:0]                wdata_i,
  input  logic [word_width_p/8-1:0]              wmask_i,
  input  logic                                   wdata_v_i,
  output logic                                   wdata_yumi_o,
  output logic [word_width_p-1:0]                rdata_o,
  output logic [mem_dram_pkg::ch_addr_width-1:0] rtag_o,
  output logic                                   rdata_v_o,
  input  logic                                   rdata_ready_i
);

  localparam int aw_lp      = $clog2(mem_words_p);
  localparam int byte_sh_lp = $clog2(word_width_p / 8);

  typedef struct packed {
    logic [mem_dram_pkg::ch_addr_width-1:0] tag;
    logic [word_width_p-1:0]                data;
  } ret_s;

  logic [word_width_p-1:0] mem_r [mem_words_p];
  logic [mem_dram_pkg::ch_addr_width-1:0] word_addr;
  logic [aw_lp-1:0] idx;
  ret_s       pend_r;
  ret_s [1:0] bank_data;
  logic       pend_v_r, pend_bank_r, enq_fire;
  logic       wr_fire, rd_fire, sel;
  logic [1:0] bank_ready, bank_v, bank_yumi;
  logic [15:0] lfsr_r;

  assign word_addr = cmd_i.ch_addr >> byte_sh_lp;
  assign idx       = word_addr[aw_lp-1:0];
  assign enq_fire  = pend_v_r & bank_ready[pend_bank_r];
  assign wr_fire   = cmd_v_i & cmd_i.write_not_read & wdata_v_i;
  assign rd_fire   = cmd_v_i & ~cmd_i.write_not_read & (~pend_v_r | enq_fire);
  assign cmd_yumi_o   = wr_fire | rd_fire;
  assign wdata_yumi_o = wr_fire;

  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      for (int b = 0; b < word_width_p / 8; b++) begin
        if (wmask_i[b]) begin
          mem_r[idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // one-cycle read stage in front of the bank queues
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pend_v_r <= 1'b0;
    end else if (rd_fire) begin
      pend_v_r <= 1'b1;
    end else if (enq_fire) begin
      pend_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      pend_r.tag  <= cmd_i.ch_addr;
      pend_r.data <= mem_r[idx];
      pend_bank_r <= word_addr[0];
    end
  end

  for (genvar g = 0; g < 2; g++) begin : bank
    sync_fifo #(
      .width_p($bits(ret_s)),
      .els_p  (4)
    ) queue (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .data_i (pend_r),
      .v_i    (pend_v_r & (pend_bank_r == 1'(g))),
      .ready_o(bank_ready[g]),
      .data_o (bank_data[g]),
      .v_o    (bank_v[g]),
      .yumi_i (bank_yumi[g])
    );
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lfsr_r <= 16'hace1;
    end else begin
      lfsr_r <= {lfsr_r[14:0], lfsr_r[15] ^ lfsr_r[13] ^ lfsr_r[12] ^ lfsr_r[10]};
    end
  end

  // random pick when both banks have data
  assign sel       = (bank_v == 2'b11) ? lfsr_r[0] : bank_v[1];
  assign rdata_v_o = |bank_v;
  assign rdata_o   = bank_data[sel].data;
  assign rtag_o    = bank_data[sel].tag;
  assign bank_yumi = {2{rdata_v_o & rdata_ready_i}} & {sel, ~sel};

endmodule

// ==== rtl/mem_to_dram.sv ====
module mem_to_dram #(
  parameter int          word_width_p = 64,
  parameter int          fifo_els_p   = 4,
  parameter logic [31:0] dram_base_p  = 32'h8000_0000
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  mem_dram_pkg::mem_msg_s                 mem_cmd_i,
  input  logic                                   mem_cmd_v_i,
  output logic                                   mem_cmd_ready_o,
  output mem_dram_pkg::mem_msg_s                 mem_resp_o,
  output logic                                   mem_resp_v_o,
  input  logic                                   mem_resp_yumi_i,
  output mem_dram_pkg::dram_cmd_s                dram_cmd_o,
  output logic                                   dram_cmd_v_o,
  input  logic                                   dram_cmd_yumi_i,
  output logic [word_width_p-1:0]                dram_wdata_o,
  output logic [word_width_p/8-1:0]              dram_wmask_o,
  output logic                                   dram_wdata_v_o,
  input  logic                                   dram_wdata_yumi_i,
  input  logic [word_width_p-1:0]                dram_rdata_i,
  input  logic [mem_dram_pkg::ch_addr_width-1:0] dram_rtag_i,
  input  logic                                   dram_rdata_v_i,
  output logic                                   dram_rdata_ready_o
);

  localparam int words_lp = mem_dram_pkg::block_width / word_width_p;

  mem_dram_pkg::mem_hdr_s  resp_hdr;
  mem_dram_pkg::dram_cmd_s block_cmd;
  logic [mem_dram_pkg::ch_addr_width-1:0] ch_addr;
  logic [31:0] addr_off;
  logic hdr_ready, hdr_v, seq_ready, seq_v, ser_ready;
  logic cmd_accept, cmd_is_write, resp_is_write;
  logic alloc_ready, ret_ready, deq_v, asm_ready, blk_v;
  logic [word_width_p-1:0] deq_data;
  logic [mem_dram_pkg::block_width-1:0] blk_data;

  assign addr_off     = mem_cmd_i.header.addr - dram_base_p;
  // block-aligned start of the word span
  assign ch_addr      = {addr_off[mem_dram_pkg::ch_addr_width-1:5], 5'b00000};
  assign cmd_is_write = (mem_cmd_i.header.msg_type == mem_dram_pkg::e_mem_wr)
                      | (mem_cmd_i.header.msg_type == mem_dram_pkg::e_mem_uc_wr);
  assign mem_cmd_ready_o = ~reset_i & hdr_ready & seq_ready & ser_ready;
  assign cmd_accept      = mem_cmd_v_i & mem_cmd_ready_o;

  assign block_cmd.write_not_read = cmd_is_write;
  assign block_cmd.ch_addr        = ch_addr;

  sync_fifo #(
    .width_p($bits(mem_dram_pkg::mem_hdr_s)),
    .els_p  (fifo_els_p)
  ) hdr_queue (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (mem_cmd_i.header),
    .v_i    (cmd_accept),
    .ready_o(hdr_ready),
    .data_o (resp_hdr),
    .v_o    (hdr_v),
    .yumi_i (mem_resp_yumi_i)
  );

  dram_word_sequencer #(
    .word_width_p(word_width_p),
    .els_p       (fifo_els_p)
  ) sequencer (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .cmd_i      (block_cmd),
    .cmd_v_i    (cmd_accept),
    .cmd_ready_o(seq_ready),
    .req_o      (dram_cmd_o),
    .req_v_o    (seq_v),
    .req_yumi_i (dram_cmd_yumi_i)
  );

  // reads hold back while the reorder buffer is full
  assign dram_cmd_v_o = seq_v & (dram_cmd_o.write_not_read | alloc_ready);

  write_data_serializer #(
    .word_width_p(word_width_p)
  ) serializer (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .addr_i (addr_off[mem_dram_pkg::ch_addr_width-1:0]),
    .size_i (mem_cmd_i.header.size),
    .data_i (mem_cmd_i.data),
    .v_i    (cmd_accept & cmd_is_write),
    .ready_o(ser_ready),
    .wdata_o(dram_wdata_o),
    .wmask_o(dram_wmask_o),
    .v_o    (dram_wdata_v_o),
    .yumi_i (dram_wdata_yumi_i)
  );

  read_reorder_buffer #(
    .word_width_p(word_width_p),
    .els_p       (fifo_els_p * words_lp)
  ) reorder (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .alloc_v_i    (dram_cmd_yumi_i & ~dram_cmd_o.write_not_read),
    .alloc_tag_i  (dram_cmd_o.ch_addr),
    .alloc_ready_o(alloc_ready),
    .ret_v_i      (dram_rdata_v_i & dram_rdata_ready_o),
    .ret_tag_i    (dram_rtag_i),
    .ret_data_i   (dram_rdata_i),
    .ret_ready_o  (ret_ready),
    .deq_data_o   (deq_data),
    .deq_v_o      (deq_v),
    .deq_yumi_i   (deq_v & asm_ready)
  );

  assign dram_rdata_ready_o = ~reset_i & ret_ready;

  read_data_assembler #(
    .word_width_p(word_width_p)
  ) assembler (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .word_i      (deq_data),
    .word_v_i    (deq_v),
    .word_ready_o(asm_ready),
    .hdr_i       (resp_hdr),
    .block_o     (blk_data),
    .block_v_o   (blk_v),
    .block_yumi_i(mem_resp_yumi_i & ~resp_is_write)
  );

  assign resp_is_write = (resp_hdr.msg_type == mem_dram_pkg::e_mem_wr)
                       | (resp_hdr.msg_type == mem_dram_pkg::e_mem_uc_wr);
  assign mem_resp_o.header = resp_hdr;
  assign mem_resp_o.data   = resp_is_write ? '0 : blk_data;
  assign mem_resp_v_o      = hdr_v & (resp_is_write | blk_v);

endmodule

// ==== rtl/read_data_assembler.sv ====
module read_data_assembler #(
  parameter int word_width_p = 64
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic [word_width_p-1:0]              word_i,
  input  logic                                 word_v_i,
  output logic                                 word_ready_o,
  input  mem_dram_pkg::mem_hdr_s               hdr_i,
  output logic [mem_dram_pkg::block_width-1:0] block_o,
  output logic                                 block_v_o,
  input  logic                                 block_yumi_i
);

  localparam int bw_lp    = mem_dram_pkg::block_width;
  localparam int words_lp = bw_lp / word_width_p;
  localparam int cnt_w_lp = (words_lp > 1) ? $clog2(words_lp) : 1;

  logic [bw_lp-1:0]    block_r, shifted;
  logic [cnt_w_lp-1:0] cnt_r;
  logic                full_r;

  assign word_ready_o = ~full_r;
  assign block_v_o    = full_r;
  assign shifted      = block_r >> {hdr_i.addr[4:0], 3'b000};

  // replicate the addressed bytes over the block
  always_comb begin
    case (hdr_i.size)
      mem_dram_pkg::e_size_1:  block_o = {32{shifted[7:0]}};
      mem_dram_pkg::e_size_2:  block_o = {16{shifted[15:0]}};
      mem_dram_pkg::e_size_4:  block_o = {8{shifted[31:0]}};
      mem_dram_pkg::e_size_8:  block_o = {4{shifted[63:0]}};
      mem_dram_pkg::e_size_16: block_o = {2{shifted[127:0]}};
      default:                 block_o = shifted;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_r  <= '0;
      full_r <= 1'b0;
    end else if (block_yumi_i) begin
      full_r <= 1'b0;
    end else if (word_v_i & ~full_r) begin
      cnt_r  <= (cnt_r == cnt_w_lp'(words_lp - 1)) ? '0 : cnt_r + 1'b1;
      full_r <= (cnt_r == cnt_w_lp'(words_lp - 1));
    end
  end

  // first word lands at the bottom once all are in
  always_ff @(posedge clk_i) begin
    if (word_v_i & ~full_r) begin
      block_r <= {word_i, block_r[bw_lp-1:word_width_p]};
    end
  end

endmodule

// ==== rtl/read_reorder_buffer.sv ====
module read_reorder_buffer #(
  parameter int word_width_p = 64,
  parameter int els_p        = 16
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic                                   alloc_v_i,
  input  logic [mem_dram_pkg::ch_addr_width-1:0] alloc_tag_i,
  output logic                                   alloc_ready_o,
  input  logic                                   ret_v_i,
  input  logic [mem_dram_pkg::ch_addr_width-1:0] ret_tag_i,
  input  logic [word_width_p-1:0]                ret_data_i,
  output logic                                   ret_ready_o,
  output logic [word_width_p-1:0]                deq_data_o,
  output logic                                   deq_v_o,
  input  logic                                   deq_yumi_i
);

  localparam int idx_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_w_lp = $clog2(els_p + 1);

  logic [mem_dram_pkg::ch_addr_width-1:0] tag_r  [els_p];
  logic [word_width_p-1:0]                data_r [els_p];
  logic [els_p-1:0]    valid_r, filled_r;
  logic [idx_w_lp-1:0] head_r, tail_r, match_idx;
  logic [cnt_w_lp-1:0] count_r;
  logic                match_found;
  logic                fill;

  assign alloc_ready_o = (count_r != cnt_w_lp'(els_p));
  assign deq_v_o       = valid_r[head_r] & filled_r[head_r];
  assign deq_data_o    = data_r[head_r];
  assign ret_ready_o   = match_found;
  assign fill          = ret_v_i & match_found;

  // walk from the head so the oldest matching slot wins
  always_comb begin
    int idx;
    match_found = 1'b0;
    match_idx   = '0;
    for (int i = els_p - 1; i >= 0; i--) begin
      idx = int'(head_r) + i;
      if (idx >= els_p) begin
        idx = idx - els_p;
      end
      if (valid_r[idx] & ~filled_r[idx] & (tag_r[idx] == ret_tag_i)) begin
        match_found = 1'b1;
        match_idx   = idx_w_lp'(idx);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r  <= '0;
      filled_r <= '0;
      head_r   <= '0;
      tail_r   <= '0;
      count_r  <= '0;
    end else begin
      if (alloc_v_i) begin
        valid_r[tail_r]  <= 1'b1;
        filled_r[tail_r] <= 1'b0;
        tail_r <= (tail_r == idx_w_lp'(els_p - 1)) ? '0 : tail_r + 1'b1;
      end
      if (fill) begin
        filled_r[match_idx] <= 1'b1;
      end
      if (deq_yumi_i) begin
        valid_r[head_r] <= 1'b0;
        head_r <= (head_r == idx_w_lp'(els_p - 1)) ? '0 : head_r + 1'b1;
      end
      count_r <= count_r + cnt_w_lp'(alloc_v_i) - cnt_w_lp'(deq_yumi_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_v_i) begin
      tag_r[tail_r] <= alloc_tag_i;
    end
    if (fill) begin
      data_r[match_idx] <= ret_data_i;
    end
  end

endmodule

// ==== rtl/write_data_serializer.sv ====
module write_data_serializer #(
  parameter int word_width_p = 64
) (
  input  logic                                   clk_i,
  input  logic                                   reset_i,
  input  logic [mem_dram_pkg::ch_addr_width-1:0] addr_i,
  input  mem_dram_pkg::mem_size_e                size_i,
  input  logic [mem_dram_pkg::block_width-1:0]   data_i,
  input  logic                                   v_i,
  output logic                                   ready_o,
  output logic [word_width_p-1:0]                wdata_o,
  output logic [word_width_p/8-1:0]              wmask_o,
  output logic                                   v_o,
  input  logic                                   yumi_i
);

  localparam int bw_lp    = mem_dram_pkg::block_width;
  localparam int words_lp = bw_lp / word_width_p;
  localparam int cnt_w_lp = (words_lp > 1) ? $clog2(words_lp) : 1;

  logic [bw_lp-1:0]   data_r;
  logic [bw_lp/8-1:0] mask_r;
  logic [63:0]        mask_full;
  logic [cnt_w_lp-1:0] cnt_r;
  logic               busy_r;

  // 2^size ones, moved to the byte offset
  assign mask_full = ((64'd1 << (1 << size_i)) - 64'd1) << addr_i[4:0];

  assign ready_o = ~busy_r;
  assign v_o     = busy_r;
  assign wdata_o = data_r[word_width_p-1:0];
  assign wmask_o = mask_r[word_width_p/8-1:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
      cnt_r  <= '0;
    end else if (v_i & ~busy_r) begin
      busy_r <= 1'b1;
      cnt_r  <= '0;
    end else if (yumi_i) begin
      cnt_r  <= cnt_r + 1'b1;
      busy_r <= (cnt_r != cnt_w_lp'(words_lp - 1));
    end
  end

  always_ff @(posedge clk_i) begin
    if (v_i & ~busy_r) begin
      data_r <= data_i << {addr_i[4:0], 3'b000};
      mask_r <= mask_full[bw_lp/8-1:0];
    end else if (yumi_i) begin
      data_r <= data_r >> word_width_p;
      mask_r <= mask_r >> (word_width_p / 8);
    end
  end

endmodule

// ==== rtl/dram_word_sequencer.sv ====
module dram_word_sequencer #(
  parameter int word_width_p = 64,
  parameter int els_p        = 4
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  mem_dram_pkg::dram_cmd_s cmd_i,
  input  logic                   cmd_v_i,
  output logic                   cmd_ready_o,
  output mem_dram_pkg::dram_cmd_s req_o,
  output logic                   req_v_o,
  input  logic                   req_yumi_i
);

  localparam int words_lp   = mem_dram_pkg::block_width / word_width_p;
  localparam int cnt_w_lp   = (words_lp > 1) ? $clog2(words_lp) : 1;
  localparam int byte_sh_lp = $clog2(word_width_p / 8);

  mem_dram_pkg::dram_cmd_s head;
  logic                    last_word;
  logic [cnt_w_lp-1:0]     cnt_r;

  sync_fifo #(
    .width_p($bits(mem_dram_pkg::dram_cmd_s)),
    .els_p  (els_p)
  ) cmd_fifo (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (cmd_i),
    .v_i    (cmd_v_i),
    .ready_o(cmd_ready_o),
    .data_o (head),
    .v_o    (req_v_o),
    .yumi_i (req_yumi_i & last_word)
  );

  assign last_word = (cnt_r == cnt_w_lp'(words_lp - 1));

  // word address inside the block
  assign req_o.write_not_read = head.write_not_read;
  assign req_o.ch_addr = head.ch_addr
                         + (mem_dram_pkg::ch_addr_width'(cnt_r) << byte_sh_lp);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_r <= '0;
    end else if (req_yumi_i) begin
      cnt_r <= last_word ? '0 : cnt_r + 1'b1;
    end
  end

endmodule

// ==== rtl/sync_fifo.sv ====
module sync_fifo #(
  parameter int width_p = 8,
  parameter int els_p   = 4
) (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic [width_p-1:0] data_i,
  input  logic               v_i,
  output logic               ready_o,
  output logic [width_p-1:0] data_o,
  output logic               v_o,
  input  logic               yumi_i
);

  localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;

  logic [width_p-1:0]  mem_r [els_p];
  logic [ptr_w_lp-1:0] rptr_r, wptr_r;
  logic                full_r;
  logic                enq, deq;

  assign ready_o = ~full_r;
  assign v_o     = full_r | (rptr_r != wptr_r);
  assign data_o  = mem_r[rptr_r];
  assign enq     = v_i & ~full_r;
  assign deq     = yumi_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rptr_r <= '0;
      wptr_r <= '0;
      full_r <= 1'b0;
    end else begin
      if (enq) begin
        wptr_r <= (wptr_r == ptr_w_lp'(els_p - 1)) ? '0 : wptr_r + 1'b1;
      end
      if (deq) begin
        rptr_r <= (rptr_r == ptr_w_lp'(els_p - 1)) ? '0 : rptr_r + 1'b1;
      end
      // full when write catches up with read
      if (enq & ~deq) begin
        full_r <= ((wptr_r == ptr_w_lp'(els_p - 1)) ? '0 : wptr_r + 1'b1) == rptr_r;
      end else if (deq & ~enq) begin
        full_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wptr_r] <= data_i;
    end
  end

endmodule

// ==== rtl/mem_dram_pkg.sv ====
package mem_dram_pkg;

  localparam int paddr_width   = 32;
  localparam int block_width   = 256;
  localparam int ch_addr_width = 16;

  typedef enum logic [1:0] {
    e_mem_rd    = 2'b00,
    e_mem_wr    = 2'b01,
    e_mem_uc_rd = 2'b10,
    e_mem_uc_wr = 2'b11
  } mem_msg_type_e;

  // log2 of the byte count
  typedef enum logic [2:0] {
    e_size_1  = 3'd0,
    e_size_2  = 3'd1,
    e_size_4  = 3'd2,
    e_size_8  = 3'd3,
    e_size_16 = 3'd4,
    e_size_32 = 3'd5
  } mem_size_e;

  typedef struct packed {
    mem_msg_type_e            msg_type;
    mem_size_e                size;
    logic [paddr_width-1:0]   addr;
  } mem_hdr_s;

  typedef struct packed {
    mem_hdr_s                 header;
    logic [block_width-1:0]   data;
  } mem_msg_s;

  typedef struct packed {
    logic                     write_not_read;
    logic [ch_addr_width-1:0] ch_addr;
  } dram_cmd_s;

endpackage
